/* hw/e100_pkg.sv */
// e100 shared types
package e100_pkg;

    localparam int word_width = 32;

    typedef logic [word_width-1:0] word_t;

    // instruction codes of the e100
    typedef enum logic [word_width-1:0] {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_be   = 32'd13,
        op_blt  = 32'd15
    } opcode_t;

    // each sequence is contiguous so control can step through it in order
    typedef enum logic [7:0] {
        st_reset,
        st_fetch1, st_fetch2, st_fetch3, st_fetch4,
        st_fetch5, st_fetch6, st_fetch7, st_fetch8,
        st_decode,
        st_halt,
        st_alu1, st_alu2, st_alu3, st_alu4, st_alu5, st_alu6,
        st_cp1, st_cp2, st_cp3, st_cp4,
        st_br1, st_br2, st_br3, st_br4, st_br5, st_br6
    } state_t;

    // whatever drives the shared bus this cycle
    typedef enum logic [3:0] {
        src_none,
        src_iar,
        src_plus1,
        src_add,
        src_sub,
        src_and,
        src_or,
        src_arg1,
        src_arg2,
        src_arg3,
        src_memory
    } bus_source_t;

endpackage

/* hw/e100_bus_if.sv */
// control to datapath bundle
interface e100_bus_if;
    import e100_pkg::*;

    // bus source and register load strobes
    bus_source_t source;
    logic        iar_write;
    logic        opcode_write;
    logic        arg1_write;
    logic        arg2_write;
    logic        arg3_write;
    logic        op1_write;
    logic        op2_write;
    logic        address_write;
    logic        memory_write;

    // status back to control
    opcode_t     opcode;
    logic        equal;
    logic        less;

    modport control (
        output source, iar_write, opcode_write, arg1_write, arg2_write, arg3_write,
               op1_write, op2_write, address_write, memory_write,
        input  opcode, equal, less
    );

    modport datapath (
        input  source, iar_write, opcode_write, arg1_write, arg2_write, arg3_write,
               op1_write, op2_write, address_write, memory_write,
        output opcode, equal, less
    );

endinterface

/* hw/e100_control.sv */
// e100 instruction sequencer
module e100_control (
    input  logic        clock,
    input  logic        reset,
    e100_bus_if.control bus,
    output logic        halted
);
    import e100_pkg::*;

    state_t state;
    state_t next_state;
    logic   branch_taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_reset;
        end else begin
            state <= next_state;
        end
    end

    assign halted = (state == st_halt);

    // be tests equality and blt the signed compare
    assign branch_taken = (bus.opcode == op_be) ? bus.equal : bus.less;

    always_comb begin
        bus.source        = src_none;
        bus.iar_write     = 1'b0;
        bus.opcode_write  = 1'b0;
        bus.arg1_write    = 1'b0;
        bus.arg2_write    = 1'b0;
        bus.arg3_write    = 1'b0;
        bus.op1_write     = 1'b0;
        bus.op2_write     = 1'b0;
        bus.address_write = 1'b0;
        bus.memory_write  = 1'b0;

        // straight-line steps just advance in encoding order
        next_state = state_t'(state + 8'd1);

        case (state)
            st_fetch1: begin
                bus.source        = src_iar;
                bus.address_write = 1'b1;
            end
            st_fetch2: begin
                bus.source       = src_memory;
                bus.opcode_write = 1'b1;
            end
            // step IAR to the next instruction word
            st_fetch3, st_fetch5, st_fetch7: begin
                bus.source        = src_plus1;
                bus.iar_write     = 1'b1;
                bus.address_write = 1'b1;
            end
            st_fetch4: begin
                bus.source     = src_memory;
                bus.arg1_write = 1'b1;
            end
            st_fetch6: begin
                bus.source     = src_memory;
                bus.arg2_write = 1'b1;
            end
            st_fetch8: begin
                bus.source     = src_memory;
                bus.arg3_write = 1'b1;
            end
            st_decode: begin
                // move IAR past arg3 to the likely next instruction
                bus.source    = src_plus1;
                bus.iar_write = 1'b1;
                case (bus.opcode)
                    op_halt: next_state = st_halt;
                    op_add, op_sub, op_and, op_or: next_state = st_alu1;
                    op_cp: next_state = st_cp1;
                    op_be, op_blt: next_state = st_br1;
                    default: next_state = st_fetch1;
                endcase
            end
            st_halt: begin
                next_state = st_halt;
            end
            // address of the first operand
            st_alu1, st_cp1, st_br1: begin
                bus.source        = src_arg2;
                bus.address_write = 1'b1;
            end
            st_alu2, st_br2: begin
                bus.source    = src_memory;
                bus.op1_write = 1'b1;
            end
            st_alu3, st_br3: begin
                bus.source        = src_arg3;
                bus.address_write = 1'b1;
            end
            st_alu4, st_br4: begin
                bus.source    = src_memory;
                bus.op2_write = 1'b1;
            end
            // destination address
            st_alu5, st_cp3: begin
                bus.source        = src_arg1;
                bus.address_write = 1'b1;
            end
            st_alu6: begin
                case (bus.opcode)
                    op_sub: bus.source = src_sub;
                    op_and: bus.source = src_and;
                    op_or: bus.source = src_or;
                    default: bus.source = src_add;
                endcase
                bus.memory_write = 1'b1;
                next_state       = st_fetch1;
            end
            // arg3 is free by now and holds the copied word
            st_cp2: begin
                bus.source     = src_memory;
                bus.arg3_write = 1'b1;
            end
            st_cp4: begin
                bus.source       = src_arg3;
                bus.memory_write = 1'b1;
                next_state       = st_fetch1;
            end
            st_br5: begin
                next_state = branch_taken ? st_br6 : st_fetch1;
            end
            st_br6: begin
                bus.source    = src_arg1;
                bus.iar_write = 1'b1;
                next_state    = st_fetch1;
            end
            default: begin
                next_state = st_fetch1;
            end
        endcase
    end

endmodule

/* hw/e100_datapath.sv */
// e100 registers, alu and shared bus
module e100_datapath (
    input  logic                clock,
    input  logic                reset,
    e100_bus_if.datapath        bus,
    input  e100_pkg::word_t     mem_read_data,
    output e100_pkg::word_t     mem_address,
    output e100_pkg::word_t     bus_value
);
    import e100_pkg::*;

    word_t iar;
    word_t opcode;
    word_t arg1;
    word_t arg2;
    word_t arg3;
    word_t op1;
    word_t op2;
    word_t address;

    // bus multiplexer
    always_comb begin
        case (bus.source)
            src_iar: bus_value = iar;
            src_plus1: bus_value = iar + word_t'(1);
            src_add: bus_value = op1 + op2;
            src_sub: bus_value = op1 - op2;
            src_and: bus_value = op1 & op2;
            src_or: bus_value = op1 | op2;
            src_arg1: bus_value = arg1;
            src_arg2: bus_value = arg2;
            src_arg3: bus_value = arg3;
            src_memory: bus_value = mem_read_data;
            default: bus_value = '0;
        endcase
    end

    // every register loads from the bus on its strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            iar     <= '0;
            opcode  <= '0;
            arg1    <= '0;
            arg2    <= '0;
            arg3    <= '0;
            op1     <= '0;
            op2     <= '0;
            address <= '0;
        end else begin
            if (bus.iar_write) iar <= bus_value;
            if (bus.opcode_write) opcode <= bus_value;
            if (bus.arg1_write) arg1 <= bus_value;
            if (bus.arg2_write) arg2 <= bus_value;
            if (bus.arg3_write) arg3 <= bus_value;
            if (bus.op1_write) op1 <= bus_value;
            if (bus.op2_write) op2 <= bus_value;
            if (bus.address_write) address <= bus_value;
        end
    end

    assign mem_address = address;

    // status for the sequencer
    assign bus.opcode = opcode_t'(opcode);
    assign bus.equal  = (op1 == op2);
    assign bus.less   = ($signed(op1) < $signed(op2));

endmodule

/* hw/e100_cpu.sv */
// e100 processor top
module e100_cpu (
    input  logic            clock,
    input  logic            reset,
    input  e100_pkg::word_t mem_read_data,
    output e100_pkg::word_t mem_address,
    output logic            mem_write,
    output e100_pkg::word_t mem_write_data,
    output logic            halted
);

    e100_bus_if bus ();

    e100_control u_control (
        .clock  (clock),
        .reset  (reset),
        .bus    (bus.control),
        .halted (halted)
    );

    // the bus value is also the memory write data
    e100_datapath u_datapath (
        .clock         (clock),
        .reset         (reset),
        .bus           (bus.datapath),
        .mem_read_data (mem_read_data),
        .mem_address   (mem_address),
        .bus_value     (mem_write_data)
    );

    assign mem_write = bus.memory_write;

endmodule

/* test/e100_checker.sv */
// e100 port assertions
module e100_checker (
    input logic clock,
    input logic reset,
    input logic mem_write,
    input logic halted
);

    int   failures = 0;
    logic reset_seen = 1'b0;

    // reset as sampled on the previous edge
    always @(posedge clock) begin
        reset_seen <= reset;
    end

    no_write_when_halted: assert property (@(posedge clock) halted |-> !mem_write)
        else begin
            $error("memory write while halted");
            failures = failures + 1;
        end

    // only reset leaves the halt state
    halt_is_sticky: assert property (@(posedge clock) (halted && !reset) |=> halted)
        else begin
            $error("halted dropped without reset");
            failures = failures + 1;
        end

    quiet_after_reset: assert property (@(posedge clock) reset_seen |-> (!mem_write && !halted))
        else begin
            $error("mem_write or halted high in the cycle after reset");
            failures = failures + 1;
        end

endmodule

bind e100_cpu e100_checker u_checker (
    .clock     (clock),
    .reset     (reset),
    .mem_write (mem_write),
    .halted    (halted)
);

/* test/e100_tb.sv */
// e100 processor testbench
module e100_tb;
    import e100_pkg::*;

    localparam int mem_words = 256;
    localparam int halt_timeout = 5000;
    localparam int step_limit = 1000;

    logic       clock;
    logic       reset;
    logic       load_request;
    logic       mem_write;
    logic       halted;
    word_t      mem_read_data;
    word_t      mem_address;
    word_t      mem_write_data;
    word_t      mem [0:mem_words-1] = '{default: 32'd0};
    word_t      image [0:mem_words-1];
    word_t      model_mem [0:mem_words-1];
    word_t      expected_address [$];
    word_t      expected_data [$];
    word_t      rng_state;
    logic [7:0] pc;
    int         expected_cycles;
    int         write_index;
    int         write_errors;
    int         error_count;
    int         tests_run;
    int         tests_failed;
    int         last_total;

    e100_cpu dut (
        .clock          (clock),
        .reset          (reset),
        .mem_read_data  (mem_read_data),
        .mem_address    (mem_address),
        .mem_write      (mem_write),
        .mem_write_data (mem_write_data),
        .halted         (halted)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // memory model indexed by the low 8 address bits
    assign mem_read_data = mem[mem_address[7:0]];

    always @(posedge clock) begin
        if (load_request) begin
            for (int i = 0; i < mem_words; i++) begin
                mem[i[7:0]] <= image[i[7:0]];
            end
        end else if (mem_write === 1'b1) begin
            mem[mem_address[7:0]] <= mem_write_data;
        end
    end

    function automatic word_t xorshift32();
        word_t x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check_word(input word_t got, input word_t expected, input string name,
                              inout int errors);
        if (got !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
                     $time, name, got, expected);
            errors = errors + 1;
        end
    endtask

    task automatic check_address(input word_t got, input word_t expected, input string name,
                                 inout int errors);
        if (got !== expected) begin
            $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h",
                     $time, name, got, expected);
            errors = errors + 1;
        end
    endtask

    task automatic check_halt_cycles(input int got, input int expected, inout int errors);
        if (got != expected) begin
            $display("CHECK FAILED time=%0t signal=halt_cycles got=%0d expected=%0d",
                     $time, got, expected);
            errors = errors + 1;
        end
    endtask

    function automatic void record_write(input word_t address, input word_t data);
        model_mem[address[7:0]] = data;
        expected_address.push_back(address);
        expected_data.push_back(data);
    endfunction

    // interprets image and returns cycles from reset release to halted
    function automatic int run_reference();
        opcode_t op;
        word_t   iar;
        word_t   a1;
        word_t   x;
        word_t   y;
        int      cycles;
        int      steps;
        int      i;
        bit      running;
        expected_address.delete();
        expected_data.delete();
        for (i = 0; i < mem_words; i++) begin
            model_mem[i[7:0]] = image[i[7:0]];
        end
        iar = 32'd0;
        cycles = 1;
        steps = 0;
        running = 1'b1;
        while (running && steps < step_limit) begin
            op = opcode_t'(model_mem[iar[7:0]]);
            a1 = model_mem[iar[7:0] + 8'd1];
            x = model_mem[model_mem[iar[7:0] + 8'd2][7:0]];
            y = model_mem[model_mem[iar[7:0] + 8'd3][7:0]];
            iar = iar + 32'd4;
            cycles = cycles + 9;
            steps = steps + 1;
            case (op)
                op_halt: running = 1'b0;
                op_add: begin
                    record_write(a1, x + y);
                    cycles = cycles + 6;
                end
                op_sub: begin
                    record_write(a1, x - y);
                    cycles = cycles + 6;
                end
                op_and: begin
                    record_write(a1, x & y);
                    cycles = cycles + 6;
                end
                op_or: begin
                    record_write(a1, x | y);
                    cycles = cycles + 6;
                end
                op_cp: begin
                    record_write(a1, x);
                    cycles = cycles + 4;
                end
                op_be, op_blt: begin
                    cycles = cycles + 5;
                    if ((op == op_be) ? (x == y) : ($signed(x) < $signed(y))) begin
                        iar = a1;
                        cycles = cycles + 1;
                    end
                end
                default: begin
                end
            endcase
        end
        return cycles;
    endfunction

    function automatic int total_errors();
        return error_count + write_errors + dut.u_checker.failures;
    endfunction

    // every store is matched against the next expected one
    always @(negedge clock) begin
        if (reset === 1'b1) begin
            write_index = 0;
        end else if (mem_write === 1'b1) begin
            if (write_index >= expected_address.size()) begin
                $display("unexpected memory write at time %0t to address %h",
                         $time, mem_address);
                write_errors = write_errors + 1;
            end else begin
                check_address(mem_address, expected_address[write_index], "mem_address",
                              write_errors);
                check_word(mem_write_data, expected_data[write_index], "mem_write_data",
                           write_errors);
            end
            write_index = write_index + 1;
        end
    end

    task automatic clear_image();
        int i;
        for (i = 0; i < mem_words; i++) begin
            image[i[7:0]] = {24'hc0de00, i[7:0]};
        end
        pc = 8'd0;
    endtask

    task automatic put_instruction(input opcode_t op, input word_t a1, input word_t a2,
                                   input word_t a3);
        image[pc] = op;
        image[pc + 8'd1] = a1;
        image[pc + 8'd2] = a2;
        image[pc + 8'd3] = a3;
        pc = pc + 8'd4;
    endtask

    // the taken branch skips a copy and the fall-through one reaches its copy
    task automatic put_branch_pair(input opcode_t op, input word_t taken_a, input word_t taken_b,
                                   input word_t fall_a, input word_t fall_b);
        put_instruction(op, 32'd8, taken_a, taken_b);
        put_instruction(op_cp, 32'd224, 32'd200, 32'd0);
        put_instruction(op, 32'd16, fall_a, fall_b);
        put_instruction(op_cp, 32'd225, 32'd201, 32'd0);
        put_instruction(op_halt, 32'd0, 32'd0, 32'd0);
    endtask

    task automatic load_and_reset();
        @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        load_request <= 1'b1;
        expected_cycles = run_reference();
        @(posedge clock);
        load_request <= 1'b0;
        @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic run_to_halt(input string name);
        int cycles;
        int i;
        int now;
        cycles = 0;
        while (halted !== 1'b1 && cycles < halt_timeout) begin
            @(posedge clock);
            cycles = cycles + 1;
            @(negedge clock);
        end
        if (halted !== 1'b1) begin
            $display("timeout waiting for halt in test %s", name);
            $display("*** FAILED ***");
            $finish;
        end else begin
            check_halt_cycles(cycles, expected_cycles, error_count);
            if (write_index != expected_address.size()) begin
                $display("test %s saw %0d memory writes where %0d were expected",
                         name, write_index, expected_address.size());
                error_count = error_count + 1;
            end
            for (i = 0; i < mem_words; i++) begin
                check_word(mem[i[7:0]], model_mem[i[7:0]], $sformatf("mem[%0d]", i),
                           error_count);
            end
            tests_run = tests_run + 1;
            now = total_errors();
            if (now != last_total) begin
                tests_failed = tests_failed + 1;
                $display("test %s: failed", name);
            end else begin
                $display("test %s: ok in %0d cycles", name, cycles);
            end
            last_total = now;
        end
    endtask

    initial begin
        opcode_t ops [7];
        opcode_t op;
        word_t   target;
        int      n;
        reset = 1'b1;
        load_request = 1'b0;
        rng_state = 32'd99063;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        last_total = 0;
        ops = '{op_add, op_sub, op_and, op_or, op_cp, op_be, op_blt};

        clear_image();
        image[8'd200] = xorshift32();
        image[8'd201] = xorshift32();
        put_instruction(op_add, 32'd210, 32'd200, 32'd201);
        put_instruction(op_sub, 32'd211, 32'd200, 32'd201);
        put_instruction(op_halt, 32'd0, 32'd0, 32'd0);
        load_and_reset();
        run_to_halt("add and sub");

        clear_image();
        image[8'd200] = xorshift32();
        image[8'd201] = xorshift32();
        put_instruction(op_and, 32'd212, 32'd200, 32'd201);
        put_instruction(op_or, 32'd213, 32'd200, 32'd201);
        put_instruction(op_cp, 32'd214, 32'd200, 32'd0);
        put_instruction(op_halt, 32'd0, 32'd0, 32'd0);
        load_and_reset();
        run_to_halt("and, or and cp");

        clear_image();
        image[8'd202] = xorshift32();
        image[8'd203] = image[8'd202];
        image[8'd204] = image[8'd202] + 32'd1;
        put_branch_pair(op_be, 32'd202, 32'd203, 32'd202, 32'd204);
        load_and_reset();
        run_to_halt("be taken and not taken");

        // negative below positive only when compared signed
        clear_image();
        image[8'd205] = xorshift32() | 32'h8000_0000;
        image[8'd206] = xorshift32() & 32'h7fff_ffff;
        put_branch_pair(op_blt, 32'd205, 32'd206, 32'd206, 32'd205);
        load_and_reset();
        run_to_halt("blt signed");

        clear_image();
        for (n = 128; n < 160; n++) begin
            image[n[7:0]] = xorshift32();
        end
        // results land in the data words and branches target the next instruction
        for (n = 0; n < 20; n++) begin
            op = ops[xorshift32() % 32'd7];
            if (op == op_be || op == op_blt) begin
                target = {24'd0, pc} + 32'd4;
            end else begin
                target = 32'd128 + (xorshift32() & 32'd31);
            end
            put_instruction(op, target,
                            32'd128 + (xorshift32() & 32'd31),
                            32'd128 + (xorshift32() & 32'd31));
        end
        put_instruction(op_halt, 32'd0, 32'd0, 32'd0);
        load_and_reset();
        run_to_halt("random program");

        load_and_reset();
        repeat (150) @(posedge clock);
        load_and_reset();
        run_to_halt("reset mid-program");

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/e100_pkg.sv
hw/e100_bus_if.sv
hw/e100_control.sv
hw/e100_datapath.sv
hw/e100_cpu.sv
test/e100_checker.sv
test/e100_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the e100 simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module e100_tb -Mdir obj_dir -f compile.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Ve100_tb +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q -F '*** FAILED ***' sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failures"
exit 0
